/* dma_backend.sv */
`timescale 1ns/1ps

module dma_backend (
  input  logic                           clk_i,
  input  logic                           arst_n_i,
  input  logic                           row_start_i,
  input  logic [dma_pkg::DMA_ADDR_W-1:0] row_src_i,
  input  logic [dma_pkg::DMA_ADDR_W-1:0] row_dst_i,
  input  logic [dma_pkg::DMA_LEN_W-1:0]  row_len_i,
  input  logic [dma_pkg::DMA_DATA_W-1:0] rd_data_i,
  output logic                           rd_req_o,
  output logic [dma_pkg::DMA_ADDR_W-1:0] rd_addr_o,
  output logic                           wr_req_o,
  output logic [dma_pkg::DMA_ADDR_W-1:0] wr_addr_o,
  output logic [dma_pkg::DMA_DATA_W-1:0] wr_data_o,
  output logic                           row_done_o
);
  import dma_pkg::*;

  logic [DMA_LEN_W-1:0]  rd_left_q;  // reads still to issue
  logic [DMA_ADDR_W-1:0] rd_addr_q;
  logic [DMA_ADDR_W-1:0] dst_addr_q; // dst of the next read
  logic [DMA_ADDR_W-1:0] wr_addr_q;  // dst of the word returning now
  logic                  wr_valid_q;
  logic                  wr_last_q;

  // --------------------
  // read side
  // --------------------
  assign rd_req_o  = (rd_left_q != '0);
  assign rd_addr_o = rd_addr_q;

  // write side, data arrives one cycle after its read
  assign wr_req_o   = wr_valid_q;
  assign wr_addr_o  = wr_addr_q;
  assign wr_data_o  = rd_data_i;
  assign row_done_o = wr_valid_q && wr_last_q; // with the last write

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_left_q  <= '0;
      wr_valid_q <= 1'b0;
      wr_last_q  <= 1'b0;
    end else begin
      if (row_start_i) begin
        rd_left_q <= row_len_i;
      end else if (rd_req_o) begin
        rd_left_q <= rd_left_q - 1'b1;
      end
      wr_valid_q <= rd_req_o;
      wr_last_q  <= rd_req_o && (rd_left_q == DMA_LEN_W'(1));
    end
  end

  // address counters and write pipe
  always_ff @(posedge clk_i) begin
    if (row_start_i) begin
      rd_addr_q  <= row_src_i;
      dst_addr_q <= row_dst_i;
    end else if (rd_req_o) begin
      rd_addr_q  <= rd_addr_q + 1'b1;
      dst_addr_q <= dst_addr_q + 1'b1;
    end
    wr_addr_q <= dst_addr_q; // travels with the read in flight
  end

endmodule

/* dma_ctrl.f */
dma_pkg.sv
dma_issue_decoder.sv
dma_job_fifo.sv
dma_nd_midend.sv
dma_backend.sv
dma_ctrl.sv
dma_ctrl_asserts.sv
dma_ctrl_tb.sv

/* dma_ctrl.sv */
`timescale 1ns/1ps

module dma_ctrl (
  input  logic                           clk_i,
  input  logic                           arst_n_i,
  input  logic                           issue_valid_i,
  input  dma_pkg::dma_instr_u            issue_instr_i,
  input  logic [dma_pkg::DMA_DATA_W-1:0] issue_rs1_i,
  input  logic [dma_pkg::DMA_DATA_W-1:0] issue_rs2_i,
  output logic                           issue_accept_o,
  output logic [dma_pkg::DMA_ID_W-1:0]   issue_id_o,
  output logic                           ext_req_o,
  output logic                           ext_we_o,
  output logic [dma_pkg::DMA_ADDR_W-1:0] ext_addr_o,
  output logic [dma_pkg::DMA_DATA_W-1:0] ext_wdata_o,
  input  logic [dma_pkg::DMA_DATA_W-1:0] ext_rdata_i,
  output logic                           loc_req_o,
  output logic                           loc_we_o,
  output logic [dma_pkg::DMA_ADDR_W-1:0] loc_addr_o,
  output logic [dma_pkg::DMA_DATA_W-1:0] loc_wdata_o,
  input  logic [dma_pkg::DMA_DATA_W-1:0] loc_rdata_i,
  output logic                           start_o,
  output logic                           busy_o,
  output logic                           done_o,
  output logic [dma_pkg::DMA_ID_W-1:0]   done_id_o,
  output logic                           error_o
);
  import dma_pkg::*;

  logic                  push;
  logic [DMA_JOB_W-1:0]  push_job;
  logic                  fifo_full;
  logic                  fifo_not_empty;
  logic [DMA_JOB_W-1:0]  head_job;
  logic                  pop;
  logic                  job_done;
  logic [DMA_ID_W-1:0]   job_id;
  logic                  mid_active;
  logic                  row_start;
  logic [DMA_ADDR_W-1:0] row_src;
  logic [DMA_ADDR_W-1:0] row_dst;
  logic [DMA_LEN_W-1:0]  row_len;
  logic                  row_dir;
  logic                  row_done;
  logic                  rd_req;
  logic [DMA_ADDR_W-1:0] rd_addr;
  logic [DMA_DATA_W-1:0] rd_data;
  logic                  wr_req;
  logic [DMA_ADDR_W-1:0] wr_addr;
  logic [DMA_DATA_W-1:0] wr_data;

  // --------------------
  // control path
  // --------------------
  dma_issue_decoder u_decoder (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .issue_valid_i  ( issue_valid_i  ),
    .issue_instr_i  ( issue_instr_i  ),
    .issue_rs1_i    ( issue_rs1_i    ),
    .issue_rs2_i    ( issue_rs2_i    ),
    .fifo_full_i    ( fifo_full      ),
    .job_done_i     ( job_done       ),
    .issue_accept_o ( issue_accept_o ),
    .issue_id_o     ( issue_id_o     ),
    .error_o        ( error_o        ),
    .push_o         ( push           ),
    .push_job_o     ( push_job       )
  );

  dma_job_fifo u_job_fifo (
    .clk_i       ( clk_i          ),
    .arst_n_i    ( arst_n_i       ),
    .push_i      ( push           ),
    .push_job_i  ( push_job       ),
    .pop_i       ( pop            ),
    .full_o      ( fifo_full      ),
    .not_empty_o ( fifo_not_empty ),
    .head_job_o  ( head_job       )
  );

  dma_nd_midend u_midend (
    .clk_i       ( clk_i          ),
    .arst_n_i    ( arst_n_i       ),
    .not_empty_i ( fifo_not_empty ),
    .head_job_i  ( head_job       ),
    .row_done_i  ( row_done       ),
    .pop_o       ( pop            ),
    .start_o     ( start_o        ),
    .row_start_o ( row_start      ),
    .row_src_o   ( row_src        ),
    .row_dst_o   ( row_dst        ),
    .row_len_o   ( row_len        ),
    .row_dir_o   ( row_dir        ),
    .job_done_o  ( job_done       ),
    .job_id_o    ( job_id         ),
    .active_o    ( mid_active     )
  );

  // --------------------
  // data path
  // --------------------
  dma_backend u_backend (
    .clk_i       ( clk_i     ),
    .arst_n_i    ( arst_n_i  ),
    .row_start_i ( row_start ),
    .row_src_i   ( row_src   ),
    .row_dst_i   ( row_dst   ),
    .row_len_i   ( row_len   ),
    .rd_data_i   ( rd_data   ),
    .rd_req_o    ( rd_req    ),
    .rd_addr_o   ( rd_addr   ),
    .wr_req_o    ( wr_req    ),
    .wr_addr_o   ( wr_addr   ),
    .wr_data_o   ( wr_data   ),
    .row_done_o  ( row_done  )
  );

  // dir 0 reads ext and writes loc, dir 1 the reverse
  assign ext_req_o   = row_dir ? wr_req : rd_req;
  assign ext_we_o    = row_dir && wr_req;  // low while ext is the source
  assign ext_addr_o  = row_dir ? wr_addr : rd_addr;
  assign ext_wdata_o = wr_data;
  assign loc_req_o   = row_dir ? rd_req : wr_req;
  assign loc_we_o    = !row_dir && wr_req; // low while loc is the source
  assign loc_addr_o  = row_dir ? rd_addr : wr_addr;
  assign loc_wdata_o = wr_data;
  assign rd_data     = row_dir ? loc_rdata_i : ext_rdata_i;

  assign busy_o    = fifo_not_empty || mid_active;
  assign done_o    = job_done;
  assign done_id_o = job_id;

endmodule

/* dma_ctrl_asserts.sv */
`timescale 1ns/1ps

module dma_ctrl_asserts (
  input logic clk_i,
  input logic arst_n_i,
  input logic start_i,
  input logic busy_i,
  input logic done_i,
  input logic error_i,
  input logic ext_req_i,
  input logic ext_we_i,
  input logic loc_req_i,
  input logic loc_we_i
);

  // --------------------
  // job level
  // --------------------
  a_start_busy: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    start_i |-> busy_i) else $error("start_o while not busy");
  a_done_error: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(done_i && error_i)) else $error("done_o and error_o together");
  a_req_busy: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (ext_req_i || loc_req_i) |-> busy_i) else $error("memory request while idle");

  // --------------------
  // memory sides
  // --------------------
  // each read lands as a write on the other side one cycle later
  a_ext_rd_loc_wr: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (ext_req_i && !ext_we_i) |=> (loc_req_i && loc_we_i))
    else $error("ext read not followed by a loc write");
  a_loc_rd_ext_wr: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (loc_req_i && !loc_we_i) |=> (ext_req_i && ext_we_i))
    else $error("loc read not followed by an ext write");
  // no write without the read that fetched its data
  a_loc_wr_src: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (loc_req_i && loc_we_i) |-> $past(ext_req_i && !ext_we_i))
    else $error("loc write without an ext read before it");
  a_ext_wr_src: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (ext_req_i && ext_we_i) |-> $past(loc_req_i && !loc_we_i))
    else $error("ext write without a loc read before it");

endmodule

bind dma_ctrl dma_ctrl_asserts u_asserts (
  .clk_i     ( clk_i     ),
  .arst_n_i  ( arst_n_i  ),
  .start_i   ( start_o   ),
  .busy_i    ( busy_o    ),
  .done_i    ( done_o    ),
  .error_i   ( error_o   ),
  .ext_req_i ( ext_req_o ),
  .ext_we_i  ( ext_we_o  ),
  .loc_req_i ( loc_req_o ),
  .loc_we_i  ( loc_we_o  )
);

/* dma_ctrl_tb.sv */
`timescale 1ns/1ps

module dma_ctrl_tb;
  import dma_pkg::*;

  localparam int MEM_WORDS    = 1 << DMA_ADDR_W;
  localparam int NJOBS        = 12;
  localparam int DONE_TIMEOUT = 2000; // cycles
  localparam int ERR_TIMEOUT  = 8;

  typedef struct packed {
    logic                  dir;        // 1 = local to external
    logic                  nd;         // use the rows field
    logic [DMA_ADDR_W-1:0] src;
    logic [DMA_ADDR_W-1:0] dst;
    logic [DMA_LEN_W-1:0]  len;
    logic [DMA_REPS_W-1:0] rows;
    logic [DMA_ADDR_W-1:0] src_stride;
    logic [DMA_ADDR_W-1:0] dst_stride;
    logic                  accept;     // START should be taken
    logic                  err;        // rejection pulses error_o
    logic                  wait_done;  // drain everything after this job
  } job_t;

  logic                  clk_i;
  logic                  arst_n_i;
  logic                  issue_valid_i;
  dma_instr_u            issue_instr_i;
  logic [DMA_DATA_W-1:0] issue_rs1_i;
  logic [DMA_DATA_W-1:0] issue_rs2_i;
  logic                  issue_accept_o;
  logic [DMA_ID_W-1:0]   issue_id_o;
  logic                  ext_req_o;
  logic                  ext_we_o;
  logic [DMA_ADDR_W-1:0] ext_addr_o;
  logic [DMA_DATA_W-1:0] ext_wdata_o;
  logic [DMA_DATA_W-1:0] ext_rdata_i = '0;
  logic                  loc_req_o;
  logic                  loc_we_o;
  logic [DMA_ADDR_W-1:0] loc_addr_o;
  logic [DMA_DATA_W-1:0] loc_wdata_o;
  logic [DMA_DATA_W-1:0] loc_rdata_i = '0;
  logic                  start_o;
  logic                  busy_o;
  logic                  done_o;
  logic [DMA_ID_W-1:0]   done_id_o;
  logic                  error_o;

  logic [DMA_DATA_W-1:0] ext_mem    [MEM_WORDS];
  logic [DMA_DATA_W-1:0] loc_mem    [MEM_WORDS];
  logic [DMA_DATA_W-1:0] ext_shadow [MEM_WORDS]; // expected contents
  logic [DMA_DATA_W-1:0] loc_shadow [MEM_WORDS];
  job_t                  jobs       [NJOBS];
  integer                seed;
  int                    accept_count = 0;
  int                    exp_errors   = 0;
  int                    done_count   = 0;
  int                    error_count  = 0;
  int                    start_count  = 0;

  dma_ctrl u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // --------------------
  // memory models
  // --------------------
  always @(posedge clk_i) begin
    if (ext_req_o && ext_we_o) begin
      ext_mem[ext_addr_o] <= ext_wdata_o;
    end
    if (ext_req_o && !ext_we_o) begin
      ext_rdata_i <= ext_mem[ext_addr_o]; // one cycle read latency
    end
    if (loc_req_o && loc_we_o) begin
      loc_mem[loc_addr_o] <= loc_wdata_o;
    end
    if (loc_req_o && !loc_we_o) begin
      loc_rdata_i <= loc_mem[loc_addr_o];
    end
  end

  // start, done and error pulses, sampled before the edge
  always @(posedge clk_i) begin
    if (arst_n_i && done_o) begin
      assert (done_count < accept_count) else fail_run("done_o pulsed with no job outstanding");
      assert (done_id_o == DMA_ID_W'(done_count))
        else value_error("done_id_o", done_id_o, DMA_ID_W'(done_count));
      done_count = done_count + 1;
    end
    if (arst_n_i && error_o) begin
      error_count = error_count + 1;
    end
    if (arst_n_i && start_o) begin
      start_count = start_count + 1; // one per job taken by the mid-end
    end
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic value_error(input string name, input logic [31:0] got, input logic [31:0] exp);
    fail_run($sformatf("Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp));
  endtask

  task automatic load_table();
    //          dir nd src   dst   len rows ss  ds  acc err wait
    jobs[0]  = '{0, 0, 10,   20,   8,  0,   0,  0,  1,  0,  1}; // 1-D ext to loc
    jobs[1]  = '{1, 1, 100,  200,  5,  3,   16, 9,  1,  0,  1}; // 2-D loc to ext
    jobs[2]  = '{0, 0, 30,   60,   0,  2,   0,  0,  0,  1,  1}; // zero length
    jobs[3]  = '{1, 1, 30,   60,   4,  0,   1,  1,  0,  1,  1}; // zero rows
    jobs[4]  = '{0, 1, 40,   300,  3,  2,   4,  2,  1,  0,  1}; // dst rows overlap
    jobs[5]  = '{0, 1, 400,  400,  12, 3,   20, 12, 1,  0,  0}; // long job holds the mid-end
    jobs[6]  = '{1, 0, 500,  600,  6,  0,   0,  0,  1,  0,  0};
    jobs[7]  = '{0, 0, 520,  700,  7,  0,   0,  0,  1,  0,  0};
    jobs[8]  = '{1, 1, 640,  760,  4,  2,   8,  5,  1,  0,  0};
    jobs[9]  = '{0, 0, 900,  900,  8,  0,   0,  0,  1,  0,  0};
    jobs[10] = '{1, 0, 950,  950,  8,  0,   0,  0,  0,  0,  1}; // fifo full
    jobs[11] = '{0, 0, 1020, 1022, 6,  0,   0,  0,  1,  0,  1}; // address wrap
  endtask

  task automatic send_instr(input logic [6:0] opcode, input logic [2:0] funct3,
                            input logic dir, input logic nd,
                            input logic [31:0] rs1, input logic [31:0] rs2,
                            output logic accepted, output logic [DMA_ID_W-1:0] id);
    dma_instr_u instr;
    instr             = '0;
    instr.cfg.opcode  = opcode;
    instr.cfg.funct3  = funct3;
    instr.start.dir   = dir;
    instr.start.nd_en = nd;
    @(posedge clk_i);
    issue_valid_i <= 1'b1;
    issue_instr_i <= instr;
    issue_rs1_i   <= rs1;
    issue_rs2_i   <= rs2;
    @(negedge clk_i);
    accepted = issue_accept_o; // same-cycle accept
    id       = issue_id_o;
  endtask

  task automatic send_config(input logic [2:0] funct3, input logic [31:0] rs1,
                             input logic [31:0] rs2);
    logic                accepted;
    logic [DMA_ID_W-1:0] id;
    send_instr(DMA_OPCODE, funct3, 1'b0, 1'b0, rs1, rs2, accepted, id);
    assert (accepted) else value_error("issue_accept_o", accepted, 1);
  endtask

  task automatic idle_issue();
    @(posedge clk_i);
    issue_valid_i <= 1'b0;
  endtask

  // word by word in issue order, so overlapping rows resolve like the DUT
  task automatic model_copy(input job_t job);
    int                    rows;
    int                    r;
    int                    i;
    logic [DMA_ADDR_W-1:0] s;
    logic [DMA_ADDR_W-1:0] d;
    rows = job.nd ? int'(job.rows) : 1;
    for (r = 0; r < rows; r++) begin
      for (i = 0; i < int'(job.len); i++) begin
        s = DMA_ADDR_W'(int'(job.src) + r * int'(job.src_stride) + i); // wraps at 1024
        d = DMA_ADDR_W'(int'(job.dst) + r * int'(job.dst_stride) + i);
        if (job.dir) begin
          ext_shadow[d] = loc_shadow[s];
        end else begin
          loc_shadow[d] = ext_shadow[s];
        end
      end
    end
  endtask

  task automatic run_job(input job_t job);
    logic                accepted;
    logic [DMA_ID_W-1:0] id;
    send_config(DMA_F3_ADDR, 32'(job.src), 32'(job.dst));
    send_config(DMA_F3_LEN, 32'(job.len), 32'(job.rows));
    send_config(DMA_F3_STRIDE, 32'(job.src_stride), 32'(job.dst_stride));
    send_instr(DMA_OPCODE, DMA_F3_START, job.dir, job.nd, '0, '0, accepted, id);
    assert (accepted == job.accept) else value_error("issue_accept_o", accepted, job.accept);
    if (accepted) begin
      assert (id == DMA_ID_W'(accept_count))
        else value_error("issue_id_o", id, DMA_ID_W'(accept_count));
      accept_count = accept_count + 1;
      model_copy(job);
    end
    if (job.err) begin
      exp_errors = exp_errors + 1;
    end
  endtask

  task automatic wait_for_errors();
    int cycles;
    cycles = 0;
    while (error_count < exp_errors) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > ERR_TIMEOUT) begin
        fail_run("timeout while waiting for error_o");
      end
    end
  endtask

  task automatic check_memories();
    int a;
    for (a = 0; a < MEM_WORDS; a++) begin
      assert (ext_mem[a] == ext_shadow[a])
        else value_error($sformatf("ext_mem[%0d]", a), ext_mem[a], ext_shadow[a]);
      assert (loc_mem[a] == loc_shadow[a])
        else value_error($sformatf("loc_mem[%0d]", a), loc_mem[a], loc_shadow[a]);
    end
  endtask

  task automatic drain_jobs();
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (done_count < accept_count) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > DONE_TIMEOUT) begin
        fail_run("timeout while waiting for done_o");
      end
    end
    assert (error_count == exp_errors) else value_error("error_o pulses", error_count, exp_errors);
    assert (start_count == accept_count)
      else value_error("start_o pulses", start_count, accept_count);
    assert (!busy_o) else value_error("busy_o", busy_o, 0);
    check_memories();
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial begin
    logic                  accepted;
    logic [DMA_ID_W-1:0]   id;
    logic [DMA_DATA_W-1:0] word;
    int                    a;
    int                    j;
    arst_n_i      = 1'b0;
    issue_valid_i = 1'b0;
    issue_instr_i = '0;
    issue_rs1_i   = '0;
    issue_rs2_i   = '0;
    seed          = 32'h60b08f78;
    for (a = 0; a < MEM_WORDS; a++) begin
      word          = $random(seed);
      ext_mem[a]    <= word;
      ext_shadow[a] = word;
      word          = $random(seed);
      loc_mem[a]    <= word;
      loc_shadow[a] = word;
    end
    load_table();
    repeat (10) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(negedge clk_i);
    assert ({issue_accept_o, start_o, done_o, error_o, busy_o,
             ext_req_o, ext_we_o, loc_req_o, loc_we_o} == '0)
      else value_error("strobes after reset", {issue_accept_o, start_o, done_o, error_o,
                       busy_o, ext_req_o, ext_we_o, loc_req_o, loc_we_o}, 0);
    assert (issue_id_o == '0) else value_error("issue_id_o", issue_id_o, 0);
    // plain OP opcode, not for the DMA
    send_instr(7'b0110011, DMA_F3_START, 1'b0, 1'b0, '0, '0, accepted, id);
    assert (!accepted) else value_error("issue_accept_o", accepted, 0);
    for (j = 0; j < NJOBS; j++) begin
      run_job(jobs[j]);
      if (jobs[j].wait_done) begin
        idle_issue();
        wait_for_errors();
        drain_jobs();
      end
    end
    $display("TB PASSED");
    $finish;
  end

endmodule

/* dma_issue_decoder.sv */
`timescale 1ns/1ps

module dma_issue_decoder (
  input  logic                           clk_i,
  input  logic                           arst_n_i,
  input  logic                           issue_valid_i,
  input  dma_pkg::dma_instr_u            issue_instr_i,
  input  logic [dma_pkg::DMA_DATA_W-1:0] issue_rs1_i,
  input  logic [dma_pkg::DMA_DATA_W-1:0] issue_rs2_i,
  input  logic                           fifo_full_i,
  input  logic                           job_done_i,
  output logic                           issue_accept_o,
  output logic [dma_pkg::DMA_ID_W-1:0]   issue_id_o,
  output logic                           error_o,
  output logic                           push_o,
  output logic [dma_pkg::DMA_JOB_W-1:0]  push_job_o
);
  import dma_pkg::*;

  logic                  is_dma;
  logic                  is_cfg;
  logic                  is_start;
  logic                  job_ok;
  logic                  id_room;
  logic [DMA_REPS_W-1:0] rows_eff;

  logic [DMA_ADDR_W-1:0] src_q;
  logic [DMA_ADDR_W-1:0] dst_q;
  logic [DMA_ADDR_W-1:0] src_stride_q;
  logic [DMA_ADDR_W-1:0] dst_stride_q;
  logic [DMA_LEN_W-1:0]  len_q;
  logic [DMA_REPS_W-1:0] rows_q;
  logic [DMA_ID_W-1:0]   next_id_q;
  logic [DMA_ID_W-1:0]   done_id_q;
  logic                  error_q;

  // --------------------
  // decode
  // --------------------
  assign is_dma   = issue_valid_i && (issue_instr_i.cfg.opcode == DMA_OPCODE);
  assign is_cfg   = is_dma && (issue_instr_i.cfg.funct3 inside
                               {DMA_F3_ADDR, DMA_F3_LEN, DMA_F3_STRIDE});
  assign is_start = is_dma && (issue_instr_i.cfg.funct3 == DMA_F3_START);

  assign rows_eff = issue_instr_i.start.nd_en ? rows_q : DMA_REPS_W'(1); // 1-D is one row
  assign job_ok   = (len_q != '0) && (rows_eff != '0);
  assign id_room  = (next_id_q - done_id_q) != '1; // keep outstanding ids distinct

  assign push_o         = is_start && job_ok && !fifo_full_i && id_room;
  assign issue_accept_o = is_cfg || push_o;
  assign issue_id_o     = next_id_q; // id handed back with the accept
  assign error_o        = error_q;

  assign push_job_o = {issue_instr_i.start.dir, next_id_q, src_q, dst_q, len_q, rows_eff,
                       src_stride_q, dst_stride_q};

  // --------------------
  // config registers
  // --------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      src_q        <= '0;
      dst_q        <= '0;
      len_q        <= '0;
      rows_q       <= '0;
      src_stride_q <= '0;
      dst_stride_q <= '0;
    end else if (is_cfg) begin
      case (issue_instr_i.cfg.funct3)
        DMA_F3_ADDR: begin
          src_q <= issue_rs1_i[DMA_ADDR_W-1:0];
          dst_q <= issue_rs2_i[DMA_ADDR_W-1:0];
        end
        DMA_F3_LEN: begin
          len_q  <= issue_rs1_i[DMA_LEN_W-1:0];
          rows_q <= issue_rs2_i[DMA_REPS_W-1:0];
        end
        default: begin // stride op
          src_stride_q <= issue_rs1_i[DMA_ADDR_W-1:0];
          dst_stride_q <= issue_rs2_i[DMA_ADDR_W-1:0];
        end
      endcase
    end
  end

  // transfer ids and error flag
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      next_id_q <= '0;
      done_id_q <= '0;
      error_q   <= 1'b0;
    end else begin
      error_q <= is_start && !job_ok; // empty job, not a full fifo
      if (push_o) begin
        next_id_q <= next_id_q + 1'b1;
      end
      if (job_done_i) begin
        done_id_q <= done_id_q + 1'b1; // jobs retire in order
      end
    end
  end

endmodule

/* dma_job_fifo.sv */
`timescale 1ns/1ps

module dma_job_fifo #(
  parameter int DEPTH = dma_pkg::DMA_FIFO_DEPTH
) (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic                          push_i,
  input  logic [dma_pkg::DMA_JOB_W-1:0] push_job_i,
  input  logic                          pop_i,
  output logic                          full_o,
  output logic                          not_empty_o,
  output logic [dma_pkg::DMA_JOB_W-1:0] head_job_o
);
  import dma_pkg::*;

  logic [DMA_JOB_W-1:0]     mem_q [DEPTH];
  logic [$clog2(DEPTH)-1:0] wr_ptr_q;
  logic [$clog2(DEPTH)-1:0] rd_ptr_q;
  logic [$clog2(DEPTH):0]   count_q;
  logic                     do_push;
  logic                     do_pop;

  assign full_o      = (count_q == DEPTH);
  assign not_empty_o = (count_q != '0);
  assign head_job_o  = mem_q[rd_ptr_q];

  assign do_push = push_i && !full_o;      // push on full is dropped
  assign do_pop  = pop_i && not_empty_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q; // both or neither
      endcase
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_job_i;
    end
  end

endmodule

/* dma_nd_midend.sv */
`timescale 1ns/1ps

module dma_nd_midend (
  input  logic                           clk_i,
  input  logic                           arst_n_i,
  input  logic                           not_empty_i,
  input  logic [dma_pkg::DMA_JOB_W-1:0]  head_job_i,
  input  logic                           row_done_i,
  output logic                           pop_o,
  output logic                           start_o,
  output logic                           row_start_o,
  output logic [dma_pkg::DMA_ADDR_W-1:0] row_src_o,
  output logic [dma_pkg::DMA_ADDR_W-1:0] row_dst_o,
  output logic [dma_pkg::DMA_LEN_W-1:0]  row_len_o,
  output logic                           row_dir_o,
  output logic                           job_done_o,
  output logic [dma_pkg::DMA_ID_W-1:0]   job_id_o,
  output logic                           active_o
);
  import dma_pkg::*;

  // head fields
  logic                  h_dir;
  logic [DMA_ID_W-1:0]   h_id;
  logic [DMA_ADDR_W-1:0] h_src;
  logic [DMA_ADDR_W-1:0] h_dst;
  logic [DMA_LEN_W-1:0]  h_len;
  logic [DMA_REPS_W-1:0] h_rows;
  logic [DMA_ADDR_W-1:0] h_src_stride;
  logic [DMA_ADDR_W-1:0] h_dst_stride;

  logic                  active_q;
  logic                  start_q;
  logic                  row_start_q;
  logic                  job_done_q;
  logic [DMA_REPS_W-1:0] rows_left_q;
  logic                  last_row;

  logic                  dir_q;
  logic [DMA_ID_W-1:0]   id_q;
  logic [DMA_LEN_W-1:0]  len_q;
  logic [DMA_ADDR_W-1:0] src_q;
  logic [DMA_ADDR_W-1:0] dst_q;
  logic [DMA_ADDR_W-1:0] src_stride_q;
  logic [DMA_ADDR_W-1:0] dst_stride_q;

  assign {h_dir, h_id, h_src, h_dst, h_len, h_rows, h_src_stride, h_dst_stride} = head_job_i;

  assign pop_o    = !active_q && not_empty_i; // take a job only when idle
  assign last_row = (rows_left_q == DMA_REPS_W'(1));

  assign start_o     = start_q;
  assign row_start_o = row_start_q;
  assign row_src_o   = src_q;
  assign row_dst_o   = dst_q;
  assign row_len_o   = len_q;
  assign row_dir_o   = dir_q;
  assign job_done_o  = job_done_q;
  assign job_id_o    = id_q; // still the old id in the done cycle
  assign active_o    = active_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      active_q    <= 1'b0;
      start_q     <= 1'b0;
      row_start_q <= 1'b0;
      job_done_q  <= 1'b0;
      rows_left_q <= '0;
    end else begin
      start_q     <= pop_o;
      row_start_q <= pop_o || (row_done_i && !last_row); // first row, then one per done
      job_done_q  <= row_done_i && last_row;
      if (pop_o) begin
        active_q    <= 1'b1;
        rows_left_q <= h_rows;
      end else if (row_done_i) begin
        rows_left_q <= rows_left_q - 1'b1;
        if (last_row) begin
          active_q <= 1'b0;
        end
      end
    end
  end

  // job payload and running row addresses
  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      dir_q        <= h_dir;
      id_q         <= h_id;
      len_q        <= h_len;
      src_q        <= h_src;
      dst_q        <= h_dst;
      src_stride_q <= h_src_stride;
      dst_stride_q <= h_dst_stride;
    end else if (row_done_i && !last_row) begin
      src_q <= src_q + src_stride_q; // next row base
      dst_q <= dst_q + dst_stride_q;
    end
  end

endmodule

/* dma_pkg.sv */
package dma_pkg;

  localparam int DMA_DATA_W     = 32; // memory word
  localparam int DMA_ADDR_W     = 10; // word address, both sides
  localparam int DMA_LEN_W      = 8;  // words per row
  localparam int DMA_REPS_W     = 4;  // rows per job
  localparam int DMA_ID_W       = 4;  // transfer id
  localparam int DMA_FIFO_DEPTH = 4;  // pending jobs

  // --------------------
  // instruction encoding
  // --------------------
  localparam logic [6:0] DMA_OPCODE    = 7'b1011011; // custom-2
  localparam logic [2:0] DMA_F3_ADDR   = 3'b000;     // rs1 src, rs2 dst
  localparam logic [2:0] DMA_F3_LEN    = 3'b001;     // rs1 len, rs2 rows
  localparam logic [2:0] DMA_F3_STRIDE = 3'b010;     // rs1 src stride, rs2 dst stride
  localparam logic [2:0] DMA_F3_START  = 3'b011;     // launch with current config

  // dir | id | src | dst | len | rows | src stride | dst stride
  localparam int DMA_JOB_W = 1 + DMA_ID_W + 4 * DMA_ADDR_W + DMA_LEN_W + DMA_REPS_W;

  // The same 32-bit word is read as an R-type config op or as a START
  // carrying its mode bits in the upper funct7 field.
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } cfg;
    struct packed {
      logic [4:0] rsvd_hi; // 31:27
      logic       nd_en;   // 26, use the rows register
      logic       dir;     // 25, 1 = local to external
      logic [9:0] rsvd_lo; // 24:15
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } start;
  } dma_instr_u;

endpackage

/* run.sh */
#!/bin/sh
# build the dma_ctrl testbench with Verilator and run it
# the exit status of the simulation is the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module dma_ctrl_tb \
  -f dma_ctrl.f -o dma_ctrl_sim \
  && ./obj_dir/dma_ctrl_sim \
  || exit 1
